/* design/frac_ram_pkg.sv */
//--------------------
// Shared types and widths of the fracturable 32 Kbit RAM
// Mode encodings 10, 14 and 15 are illegal and never stored
//--------------------

package frac_ram_pkg;

    // Native address, bank word and bank index widths
    localparam int ADDR_W  = 15;
    localparam int WORD_W  = 32;
    localparam int INDEX_W = 10;

    // Operating modes, single-port first, encoding 10 left out
    typedef enum logic [3:0] {
        sp_512x64   = 4'd0,
        sp_1024x32  = 4'd1,
        sp_2048x16  = 4'd2,
        sp_4096x8   = 4'd3,
        sp_8192x4   = 4'd4,
        sp_16384x2  = 4'd5,
        sp_32768x1  = 4'd6,
        dp_1024x32  = 4'd7,
        dp_2048x16  = 4'd8,
        dp_4096x8   = 4'd9,
        dp_8192x4   = 4'd11,
        dp_16384x2  = 4'd12,
        dp_32768x1  = 4'd13
    } frac_ram_mode_e;

    // Log2 of the number of lanes per bank word
    typedef enum logic [2:0] {
        w32 = 3'd0,
        w16 = 3'd1,
        w8  = 3'd2,
        w4  = 3'd3,
        w2  = 3'd4,
        w1  = 3'd5
    } lane_width_e;

    localparam frac_ram_mode_e MODE_RESET = sp_1024x32;

endpackage

/* design/frac_ram_ctrl.sv */
//--------------------
// AXI4-Lite mode register and bank routing
// MODE at 0x0 (bits 3:0), ID at 0x4; writes to ID or other addresses get SLVERR
// A new mode reaches the native ports one cycle after bvalid rises
//--------------------
`timescale 1ns/1ps

module frac_ram_ctrl #(
    parameter int AXI_ADDR_W = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [AXI_ADDR_W-1:0]           awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [31:0]                     wdata,
    input  logic [3:0]                      wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [AXI_ADDR_W-1:0]           araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    input  logic [frac_ram_pkg::ADDR_W-1:0] addr_a,
    input  logic [frac_ram_pkg::WORD_W-1:0] data_b,
    input  logic                            we_a,
    input  logic [frac_ram_pkg::ADDR_W-1:0] addr_b,
    input  logic                            we_b,
    output frac_ram_pkg::lane_width_e       width,
    output logic                            bank_a_we,
    output logic                            bank_b_we,
    output logic                            bank_b_rd,
    output logic [frac_ram_pkg::ADDR_W-1:0] bank_b_addr,
    output logic [frac_ram_pkg::WORD_W-1:0] bank_b_data
);
    import frac_ram_pkg::*;

    localparam logic [1:0]            RESP_OKAY   = 2'b00;
    localparam logic [1:0]            RESP_SLVERR = 2'b10;
    localparam logic [31:0]           ID_VALUE    = 32'h0000_F32C;
    localparam logic [AXI_ADDR_W-1:0] REG_MODE    = AXI_ADDR_W'(0);
    localparam logic [AXI_ADDR_W-1:0] REG_ID      = AXI_ADDR_W'(4);

    typedef enum logic [1:0] {idle, got_addr, got_data, resp} wr_state_e;

    wr_state_e             state;
    wr_state_e             state_next;
    frac_ram_mode_e        mode;
    frac_ram_mode_e        mode_new;
    logic                  mode_upd;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  ar_hs;
    logic                  commit;
    logic [AXI_ADDR_W-1:0] aw_addr_q;
    logic [3:0]            w_data_q;
    logic                  w_strb_q;
    logic [AXI_ADDR_W-1:0] addr_use;
    logic [3:0]            data_use;
    logic                  strb_use;
    logic [1:0]            wr_resp;
    logic                  wr_mode;

    function automatic logic mode_legal(logic [3:0] code);
        return (code <= 4'd9) || (code >= 4'd11 && code <= 4'd13);
    endfunction

    //--------------------
    // Write channel FSM
    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign bvalid = (state == resp);
    assign commit = (state == idle && aw_hs && w_hs) || (state == got_addr && w_hs)
                    || (state == got_data && aw_hs);

    // Either half may have been parked in a holding register
    assign addr_use = (state == got_addr) ? aw_addr_q : awaddr;
    assign data_use = (state == got_data) ? w_data_q : wdata[3:0];
    assign strb_use = (state == got_data) ? w_strb_q : wstrb[0];

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (aw_hs && w_hs) begin
                    state_next = resp;
                end else if (aw_hs) begin
                    state_next = got_addr;
                end else if (w_hs) begin
                    state_next = got_data;
                end
            end
            got_addr: if (w_hs) state_next = resp;
            got_data: if (aw_hs) state_next = resp;
            default:  if (bready) state_next = idle;
        endcase
    end

    always_comb begin
        wr_resp = RESP_OKAY;
        wr_mode = 1'b0;
        if (addr_use != REG_MODE) begin
            wr_resp = RESP_SLVERR;
        end else if (strb_use) begin
            if (mode_legal(data_use)) begin
                wr_mode = 1'b1;
            end else begin
                wr_resp = RESP_SLVERR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= idle;
            awready  <= 1'b0;
            wready   <= 1'b0;
            mode_upd <= 1'b0;
            mode     <= MODE_RESET;
        end else begin
            state    <= state_next;
            awready  <= (state_next == idle) || (state_next == got_data);
            wready   <= (state_next == idle) || (state_next == got_addr);
            mode_upd <= commit && wr_mode;
            if (mode_upd) begin
                mode <= mode_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr;
        end
        if (w_hs) begin
            w_data_q <= wdata[3:0];
            w_strb_q <= wstrb[0];
        end
        if (commit) begin
            bresp    <= wr_resp;
            mode_new <= frac_ram_mode_e'(data_use);
        end
    end

    //--------------------
    // Read channel, one outstanding read
    assign ar_hs = arvalid && arready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (ar_hs) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rresp <= RESP_OKAY;
            if (araddr == REG_MODE) begin
                rdata <= {28'd0, mode};
            end else if (araddr == REG_ID) begin
                rdata <= ID_VALUE;
            end else begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
    end

    //--------------------
    // Mode decode and bank b routing
    assign bank_a_we = we_a;

    always_comb begin
        case (mode)
            sp_2048x16, dp_2048x16: width = w16;
            sp_4096x8, dp_4096x8:   width = w8;
            sp_8192x4, dp_8192x4:   width = w4;
            sp_16384x2, dp_16384x2: width = w2;
            sp_32768x1, dp_32768x1: width = w1;
            default:                width = w32;
        endcase
    end

    always_comb begin
        // Single-port modes other than 512x64 leave bank b idle so q_b holds
        bank_b_we   = 1'b0;
        bank_b_rd   = 1'b0;
        bank_b_addr = '0;
        bank_b_data = '0;
        if (mode == sp_512x64) begin
            bank_b_we   = we_a;
            bank_b_rd   = 1'b1;
            bank_b_addr = addr_a;
            bank_b_data = data_b;
        end else if (mode >= dp_1024x32) begin
            bank_b_we   = we_b;
            bank_b_rd   = 1'b1;
            bank_b_addr = addr_b;
            bank_b_data = data_b;
        end
    end

endmodule

/* design/frac_ram_lane.sv */
//--------------------
// Lane split and extract for one native port
// Lane 0 sits in the low bits of the bank word; reads are zero-extended
// q stays zero after reset until the first read
//--------------------
`timescale 1ns/1ps

module frac_ram_lane (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [frac_ram_pkg::ADDR_W-1:0]  addr,
    input  logic [frac_ram_pkg::WORD_W-1:0]  data,
    input  logic                             we,
    input  logic                             rd,
    input  frac_ram_pkg::lane_width_e        width,
    input  logic [frac_ram_pkg::WORD_W-1:0]  rd_word,
    output logic [frac_ram_pkg::INDEX_W-1:0] index,
    output logic [frac_ram_pkg::WORD_W-1:0]  wr_mask,
    output logic [frac_ram_pkg::WORD_W-1:0]  wr_word,
    output logic [frac_ram_pkg::WORD_W-1:0]  q
);
    import frac_ram_pkg::*;

    logic [4:0]  lane;
    logic [4:0]  lane_q;
    lane_width_e width_q;
    logic        rd_seen;

    // Ones over one lane of the given width
    function automatic logic [WORD_W-1:0] field_mask(lane_width_e w);
        return {WORD_W{1'b1}} >> (WORD_W - (WORD_W >> w));
    endfunction

    // Bit offset of a lane inside the word
    function automatic logic [4:0] lane_shift(lane_width_e w, logic [4:0] n);
        return n << (3'd5 - 3'(w));
    endfunction

    //--------------------
    // Write side
    assign lane    = addr[4:0] & 5'((6'd1 << width) - 6'd1);
    assign index   = INDEX_W'(addr >> width);
    assign wr_mask = field_mask(width) << lane_shift(width, lane);

    // Replicated data lets the mask alone pick the lane
    always_comb begin
        case (width)
            w16:     wr_word = {2{data[15:0]}};
            w8:      wr_word = {4{data[7:0]}};
            w4:      wr_word = {8{data[3:0]}};
            w2:      wr_word = {16{data[1:0]}};
            w1:      wr_word = {32{data[0]}};
            default: wr_word = data;
        endcase
    end

    //--------------------
    // Read side, select delayed to match the bank register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_q  <= '0;
            width_q <= w32;
            rd_seen <= 1'b0;
        end else if (rd && !we) begin
            lane_q  <= lane;
            width_q <= width;
            rd_seen <= 1'b1;
        end
    end

    assign q = rd_seen ? (rd_word >> lane_shift(width_q, lane_q)) & field_mask(width_q)
                       : '0;

endmodule

/* design/frac_ram_bank.sv */
//--------------------
// One bank of 32-bit words with per-bit write mask
// Contents are not initialized; read word updates only on reads
//--------------------
`timescale 1ns/1ps

module frac_ram_bank #(
    parameter int DEPTH = 1024
) (
    input  logic                             clk,
    input  logic [frac_ram_pkg::INDEX_W-1:0] index,
    input  logic                             we,
    input  logic [frac_ram_pkg::WORD_W-1:0]  wr_mask,
    input  logic [frac_ram_pkg::WORD_W-1:0]  wr_word,
    input  logic                             rd,
    output logic [frac_ram_pkg::WORD_W-1:0]  rd_word
);
    import frac_ram_pkg::*;

    logic [WORD_W-1:0] mem [DEPTH];

    // Bit write enables, one per column
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < WORD_W; i++) begin
                if (wr_mask[i]) begin
                    mem[index][i] <= wr_word[i];
                end
            end
        end
    end

    // Read word is held through writes
    always_ff @(posedge clk) begin
        if (rd && !we) begin
            rd_word <= mem[index];
        end
    end

endmodule

/* design/frac_ram_top.sv */
//--------------------
// Fracturable 32 Kbit RAM, two 1024x32 banks
// In sp_512x64 keep addr_a[14:9] low; both banks share addr_a
//--------------------
`timescale 1ns/1ps

module frac_ram_top #(
    parameter int AXI_ADDR_W = 4,
    parameter int DEPTH      = 1024
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // AXI4-Lite mode register
    input  logic [AXI_ADDR_W-1:0]           awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [31:0]                     wdata,
    input  logic [3:0]                      wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [AXI_ADDR_W-1:0]           araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    // Native memory ports
    input  logic [frac_ram_pkg::ADDR_W-1:0] addr_a,
    input  logic [frac_ram_pkg::WORD_W-1:0] data_a,
    input  logic                            we_a,
    output logic [frac_ram_pkg::WORD_W-1:0] q_a,
    input  logic [frac_ram_pkg::ADDR_W-1:0] addr_b,
    input  logic [frac_ram_pkg::WORD_W-1:0] data_b,
    input  logic                            we_b,
    output logic [frac_ram_pkg::WORD_W-1:0] q_b
);
    import frac_ram_pkg::*;

    lane_width_e        width;
    logic               bank_a_we;
    logic               bank_b_we;
    logic               bank_b_rd;
    logic [ADDR_W-1:0]  bank_b_addr;
    logic [WORD_W-1:0]  bank_b_data;
    logic [INDEX_W-1:0] index_a;
    logic [INDEX_W-1:0] index_b;
    logic [WORD_W-1:0]  wr_mask_a;
    logic [WORD_W-1:0]  wr_mask_b;
    logic [WORD_W-1:0]  wr_word_a;
    logic [WORD_W-1:0]  wr_word_b;
    logic [WORD_W-1:0]  rd_word_a;
    logic [WORD_W-1:0]  rd_word_b;

    frac_ram_ctrl #(
        .AXI_ADDR_W (AXI_ADDR_W)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .addr_a      (addr_a),
        .data_b      (data_b),
        .we_a        (we_a),
        .addr_b      (addr_b),
        .we_b        (we_b),
        .width       (width),
        .bank_a_we   (bank_a_we),
        .bank_b_we   (bank_b_we),
        .bank_b_rd   (bank_b_rd),
        .bank_b_addr (bank_b_addr),
        .bank_b_data (bank_b_data)
    );

    // Port a always owns bank a and reads whenever it does not write
    frac_ram_lane u_lane_a (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr_a),
        .data    (data_a),
        .we      (bank_a_we),
        .rd      (1'b1),
        .width   (width),
        .rd_word (rd_word_a),
        .index   (index_a),
        .wr_mask (wr_mask_a),
        .wr_word (wr_word_a),
        .q       (q_a)
    );

    frac_ram_lane u_lane_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (bank_b_addr),
        .data    (bank_b_data),
        .we      (bank_b_we),
        .rd      (bank_b_rd),
        .width   (width),
        .rd_word (rd_word_b),
        .index   (index_b),
        .wr_mask (wr_mask_b),
        .wr_word (wr_word_b),
        .q       (q_b)
    );

    frac_ram_bank #(
        .DEPTH (DEPTH)
    ) u_bank_a (
        .clk     (clk),
        .index   (index_a),
        .we      (bank_a_we),
        .wr_mask (wr_mask_a),
        .wr_word (wr_word_a),
        .rd      (1'b1),
        .rd_word (rd_word_a)
    );

    frac_ram_bank #(
        .DEPTH (DEPTH)
    ) u_bank_b (
        .clk     (clk),
        .index   (index_b),
        .we      (bank_b_we),
        .wr_mask (wr_mask_b),
        .wr_word (wr_word_b),
        .rd      (bank_b_rd),
        .rd_word (rd_word_b)
    );

endmodule

/* verif/frac_ram_clkgen.sv */
//--------------------
// Clock and reset for the testbench
// 10 ns clock; rst_n is low for the first 8 rising edges
//--------------------
`timescale 1ns/1ps

module frac_ram_clkgen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    always begin
        clk = 1'b0;
        #(HALF_PERIOD);
        clk = 1'b1;
        #(HALF_PERIOD);
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* verif/frac_ram_sva.sv */
//--------------------
// Protocol and routing assertions for frac_ram_ctrl
// Bound to every frac_ram_ctrl instance
//--------------------
`timescale 1ns/1ps

module frac_ram_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        awready,
    input logic        wready,
    input logic        arready,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic [3:0]  mode,
    input logic        bank_b_we
);

    // Write response is held while the master stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid or bresp changed before bready");

    // Read data is held while the master stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    // Single-port modes other than 512x64 never write bank b
    assert property (@(posedge clk) disable iff (!rst_n)
        (mode >= 4'd1 && mode <= 4'd6) |-> !bank_b_we)
        else $error("bank b written in a single-port narrow mode");

    // Ready outputs come out of reset low
    assert property (@(posedge clk)
        !rst_n |=> !awready && !wready && !arready)
        else $error("AXI ready high during reset");

endmodule

bind frac_ram_ctrl frac_ram_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .awready   (awready),
    .wready    (wready),
    .arready   (arready),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .mode      (mode),
    .bank_b_we (bank_b_we)
);

/* verif/frac_ram_tb.sv */
//--------------------
// Testbench for frac_ram_top, driven from verif/frac_ram_vectors.txt
// Run from the project root; the run stops at the first mismatch
//--------------------
`timescale 1ns/1ps

module frac_ram_tb;
    import frac_ram_pkg::*;

    localparam int    AXI_ADDR_W = 4;
    localparam int    DEPTH      = 1024;
    localparam string VEC_FILE   = "verif/frac_ram_vectors.txt";

    logic                  clk;
    logic                  rst_n;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic [ADDR_W-1:0]     addr_a;
    logic [WORD_W-1:0]     data_a;
    logic                  we_a;
    logic [WORD_W-1:0]     q_a;
    logic [ADDR_W-1:0]     addr_b;
    logic [WORD_W-1:0]     data_b;
    logic                  we_b;
    logic [WORD_W-1:0]     q_b;

    // Parsed vectors, one entry per operation
    logic [7:0]            op_q [$];
    logic [31:0]           f1_q [$];
    logic [31:0]           f2_q [$];
    logic [31:0]           f3_q [$];
    logic [31:0]           f4_q [$];
    logic [31:0]           rng_state;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;
    int                    vec_idx = 0;

    frac_ram_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    frac_ram_top #(
        .AXI_ADDR_W (AXI_ADDR_W),
        .DEPTH      (DEPTH)
    ) u_frac_ram_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .addr_a  (addr_a),
        .data_a  (data_a),
        .we_a    (we_a),
        .q_a     (q_a),
        .addr_b  (addr_b),
        .data_b  (data_b),
        .we_b    (we_b),
        .q_b     (q_b)
    );

    //--------------------
    // Failure reporting and random stalls
    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: vector %0d, %s: got %h, expected %h",
                     $time, vec_idx, what, actual, expected);
            stop_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Stall of 0 to 5 cycles on bready or rready
    task automatic pick_stall(output int stall);
        rng_state = xorshift32(rng_state);
        stall = int'(rng_state % 32'd6);
    endtask

    // Abort when the run outlasts its budget
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: no finish after %0d clock cycles", cycle_count);
            stop_run();
        end
    end

    //--------------------
    // Vector file
    task automatic load_vectors();
        int               fd;
        int               code;
        int               nf;
        int               want;
        logic [7:0]       op;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [31:0]      f4;
        logic [8*160-1:0] rest;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vectors file %s", VEC_FILE);
            stop_run();
        end
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op == "#") begin
                code = $fgets(rest, fd);
            end else begin
                f4 = '0;
                want = (op == "C" || op == "D" || op == "Q") ? 4 : 3;
                nf = $fscanf(fd, " %h %h %h", f1, f2, f3);
                if (want == 4 && nf == 3) begin
                    nf = nf + $fscanf(fd, " %h", f4);
                end
                if (nf != want || !(op inside {"C", "R", "W", "E", "D", "Q"})) begin
                    $display("Bad line for operation %0d in %s", op_q.size(), VEC_FILE);
                    stop_run();
                end
                op_q.push_back(op);
                f1_q.push_back(f1);
                f2_q.push_back(f2);
                f3_q.push_back(f3);
                f4_q.push_back(f4);
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
    endtask

    //--------------------
    // AXI4-Lite master
    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp);
        logic       aw_pend;
        logic       w_pend;
        logic       aw_fire;
        logic       w_fire;
        logic [1:0] resp_seen;
        int         stall;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        while (aw_pend || w_pend) begin
            @(negedge clk);
            aw_fire = aw_pend && awready;
            w_fire  = w_pend && wready;
            @(posedge clk);
            if (aw_fire) begin
                awvalid <= 1'b0;
                aw_pend = 1'b0;
            end
            if (w_fire) begin
                wvalid <= 1'b0;
                w_pend = 1'b0;
            end
        end
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp_seen = bresp;
        pick_stall(stall);
        repeat (stall) begin
            @(negedge clk);
            check_value(32'(bvalid), 32'd1, "bvalid under stall");
            check_value(32'(bresp), 32'(resp_seen), "bresp under stall");
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        check_value(32'(resp_seen), 32'(exp_resp), "bresp");
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        logic        ar_fire;
        logic [31:0] data_seen;
        logic [1:0]  resp_seen;
        int          stall;
        ar_fire = 1'b0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        while (!ar_fire) begin
            @(negedge clk);
            ar_fire = arready;
            @(posedge clk);
        end
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data_seen = rdata;
        resp_seen = rresp;
        pick_stall(stall);
        repeat (stall) begin
            @(negedge clk);
            check_value(32'(rvalid), 32'd1, "rvalid under stall");
            check_value(rdata, data_seen, "rdata under stall");
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        check_value(data_seen, exp_data, "rdata");
        check_value(32'(resp_seen), 32'(exp_resp), "rresp");
    endtask

    //--------------------
    // Native ports, read data one edge after the sampling edge
    task automatic native_write(input logic port, input logic [ADDR_W-1:0] addr,
                                input logic [WORD_W-1:0] data);
        @(posedge clk);
        if (port) begin
            addr_b <= addr;
            data_b <= data;
            we_b   <= 1'b1;
        end else begin
            addr_a <= addr;
            data_a <= data;
            we_a   <= 1'b1;
        end
        @(posedge clk);
        we_a <= 1'b0;
        we_b <= 1'b0;
    endtask

    task automatic native_read(input logic port, input logic [ADDR_W-1:0] addr,
                               input logic [WORD_W-1:0] exp_q);
        @(posedge clk);
        if (port) begin
            addr_b <= addr;
            we_b   <= 1'b0;
        end else begin
            addr_a <= addr;
            we_a   <= 1'b0;
        end
        @(posedge clk);
        @(negedge clk);
        check_value(port ? q_b : q_a, exp_q, port ? "q_b" : "q_a");
    endtask

    task automatic dual_write(input logic [ADDR_W-1:0] a_addr, input logic [WORD_W-1:0] a_data,
                              input logic [ADDR_W-1:0] b_addr, input logic [WORD_W-1:0] b_data);
        @(posedge clk);
        addr_a <= a_addr;
        data_a <= a_data;
        we_a   <= 1'b1;
        addr_b <= b_addr;
        data_b <= b_data;
        we_b   <= 1'b1;
        @(posedge clk);
        we_a <= 1'b0;
        we_b <= 1'b0;
    endtask

    task automatic dual_read(input logic [ADDR_W-1:0] a_addr, input logic [WORD_W-1:0] a_q,
                             input logic [ADDR_W-1:0] b_addr, input logic [WORD_W-1:0] b_q);
        @(posedge clk);
        addr_a <= a_addr;
        we_a   <= 1'b0;
        addr_b <= b_addr;
        we_b   <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value(q_a, a_q, "q_a");
        check_value(q_b, b_q, "q_b");
    endtask

    task automatic run_vector(input int i);
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        f1 = f1_q[i];
        f2 = f2_q[i];
        f3 = f3_q[i];
        f4 = f4_q[i];
        case (op_q[i])
            "C":     axi_write(f1[AXI_ADDR_W-1:0], f2, f3[3:0], f4[1:0]);
            "R":     axi_read(f1[AXI_ADDR_W-1:0], f2, f3[1:0]);
            "W":     native_write(f1[0], f2[ADDR_W-1:0], f3);
            "E":     native_read(f1[0], f2[ADDR_W-1:0], f3);
            "D":     dual_write(f1[ADDR_W-1:0], f2, f3[ADDR_W-1:0], f4);
            default: dual_read(f1[ADDR_W-1:0], f2, f3[ADDR_W-1:0], f4);
        endcase
    endtask

    //--------------------
    // Main sequence
    initial begin
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        addr_a    = '0;
        data_a    = '0;
        we_a      = 1'b0;
        addr_b    = '0;
        data_b    = '0;
        we_b      = 1'b0;
        rng_state = 32'd68136;
        load_vectors();
        cycle_limit = 30 * op_q.size() + 200;
        wait (rst_n);
        repeat (2) @(posedge clk);
        foreach (op_q[i]) begin
            vec_idx = i;
            run_vector(i);
        end
        repeat (2) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verif/frac_ram_vectors.txt */
# Hex fields: C addr data strb bresp | R addr rdata rresp | W port addr data | E port addr q
# D addr_a data_a addr_b data_b | Q addr_a q_a addr_b q_b   (port 0 = a, 1 = b)
R 0 00000001 0
R 4 0000f32c 0
R 8 00000000 2
C 0 0000000a 1 2
C 0 0000000e 1 2
C 0 0000000f 1 2
C 8 00000002 1 2
C 4 00000001 1 2
C 0 00000003 e 0
R 0 00000001 0
W 0 0005 a5c39e17
E 0 0005 a5c39e17
C 0 00000008 1 0
R 0 00000008 0
C 0 0000000b 1 0
R 0 0000000b 0
C 0 0000000d 1 0
R 0 0000000d 0
C 0 00000007 1 0
R 0 00000007 0
D 0010 11112222 0020 33334444
Q 0010 11112222 0020 33334444
C 0 00000009 1 0
R 0 00000009 0
D 0040 000000aa 0083 00000055
Q 0041 00000022 0083 00000055
C 0 0000000c 1 0
R 0 0000000c 0
D 0100 00000001 020f 00000003
Q 0100 00000001 020f 00000003
C 0 00000000 1 0
R 0 00000000 0
D 0100 0badf00d 0000 cafe1234
Q 0100 0badf00d 0000 cafe1234
C 0 00000002 1 0
R 0 00000002 0
W 0 000a ffff1234
Q 000b 0000a5c3 0000 cafe1234
E 0 000a 00001234
C 0 00000003 1 0
R 0 00000003 0
W 0 0016 abcdef77
E 0 0017 000000a5
E 0 0016 00000077
C 0 00000004 1 0
R 0 00000004 0
W 0 002f fffffff6
E 0 002e 00000005
E 0 002f 00000006
C 0 00000005 1 0
R 0 00000005 0
W 0 0050 fffffffe
E 0 0051 00000001
E 0 0050 00000002
C 0 00000006 1 0
R 0 00000006 0
W 0 00a1 fffffffe
Q 00a2 00000001 0123 cafe1234
E 0 00a1 00000000
C 0 00000001 1 0
R 0 00000001 0
E 0 0005 65771234
E 0 0010 111122a9
E 0 0100 0badf00d

/* frac_ram.f */
design/frac_ram_pkg.sv
design/frac_ram_ctrl.sv
design/frac_ram_lane.sv
design/frac_ram_bank.sv
design/frac_ram_top.sv
verif/frac_ram_clkgen.sv
verif/frac_ram_sva.sv
verif/frac_ram_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frac_ram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module frac_ram_tb -f frac_ram.f -o frac_ram_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/frac_ram_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
